// ==== bench/tb_clock_calendar.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_calendar
    import clock_pkg::*;
();

    localparam int TPS      = 40;
    localparam int H_PERIOD = 4 * (int'(H_ACTIVE) + int'(H_FRONT) + int'(H_SYNC) + int'(H_BACK));
    localparam int V_LINES  = int'(V_ACTIVE) + int'(V_FRONT) + int'(V_SYNC) + int'(V_BACK);
    localparam int H_LOW    = 4 * int'(H_SYNC);
    localparam int V_LOW    = int'(V_SYNC) * H_PERIOD;
    localparam int TIMEOUT_CYCLES = 2000 * TPS + 2 * H_PERIOD * V_LINES;

    // set pulse bit positions
    localparam int P_HR   = 0;
    localparam int P_MIN  = 1;
    localparam int P_AMPM = 2;
    localparam int P_MON  = 3;
    localparam int P_DAY  = 4;
    localparam int P_YEAR = 5;
    localparam int P_CENT = 6;

    logic        clk_100MHz;
    logic        rst_n;
    logic        inc_hr;
    logic        inc_min;
    logic        toggle_am_pm;
    logic        inc_month;
    logic        inc_day;
    logic        inc_year;
    logic        inc_cent;
    logic        blink;
    logic        hsync;
    logic        vsync;
    logic [11:0] rgb;
    logic [24:0] time_digits;
    logic [31:0] date_digits;

    // reference model state
    int m_hr;
    int m_mn;
    int m_sc;
    bit m_pm;
    int m_mon;
    int m_day;
    int m_yr;
    int m_cen;
    int m_edges;          // rising edges since reset release
    bit carry_seen;

    logic [31:0] lcg_state = 32'd83;
    int unsigned total_cycles = 0;

    clock_calendar_top #(
        .TICKS_PER_SEC (TPS)
    ) u_clock_calendar_top (
        .clk_100MHz   (clk_100MHz),
        .rst_n        (rst_n),
        .inc_hr       (inc_hr),
        .inc_min      (inc_min),
        .toggle_am_pm (toggle_am_pm),
        .inc_month    (inc_month),
        .inc_day      (inc_day),
        .inc_year     (inc_year),
        .inc_cent     (inc_cent),
        .blink        (blink),
        .hsync        (hsync),
        .vsync        (vsync),
        .rgb          (rgb),
        .time_digits  (time_digits),
        .date_digits  (date_digits)
    );

    initial begin
        clk_100MHz = 1'b0;
        forever #5 clk_100MHz = ~clk_100MHz;
    end

    //////////////////////////////////////////////////
    // failure reporting and the compare task
    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            stop_with_error($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    always @(posedge clk_100MHz) begin
        total_cycles++;
        if (total_cycles >= TIMEOUT_CYCLES)
            stop_with_error($sformatf("timeout, run still busy after %0d cycles",
                                      total_cycles));
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    //////////////////////////////////////////////////
    // model of time and date
    function automatic logic [7:0] to_bcd(input int v);
        return {4'(v / 10), 4'(v % 10)};
    endfunction

    function automatic int next_hour(input int h);
        return (h == 12) ? 1 : h + 1;
    endfunction

    function automatic int month_days(input int m, input int y, input int c);
        bit leap;
        leap = (y != 0) ? (y % 4 == 0) : (c % 4 == 0);
        if (m == 2)
            return leap ? 29 : 28;
        if (m == 4 || m == 6 || m == 9 || m == 11)
            return 30;
        return 31;
    endfunction

    function automatic logic [24:0] exp_time();
        return {to_bcd(m_hr), to_bcd(m_mn), to_bcd(m_sc), m_pm};
    endfunction

    function automatic logic [31:0] exp_date();
        return {to_bcd(m_mon), to_bcd(m_day), to_bcd(m_cen), to_bcd(m_yr)};
    endfunction

    task automatic reset_model();
        m_hr       = 12;
        m_mn       = 0;
        m_sc       = 0;
        m_pm       = 1'b0;
        m_mon      = 1;
        m_day      = 1;
        m_yr       = 0;
        m_cen      = 20;
        m_edges    = 0;
        carry_seen = 1'b0;
    endtask

    task automatic advance_day();
        if (m_day == month_days(m_mon, m_yr, m_cen)) begin
            m_day = 1;
            if (m_mon == 12) begin
                m_mon = 1;
                if (m_yr == 99) begin
                    m_yr  = 0;
                    m_cen = (m_cen + 1) % 100;
                end else begin
                    m_yr++;
                end
            end else begin
                m_mon++;
            end
        end else begin
            m_day++;
        end
    endtask

    // state after the next rising edge
    task automatic advance_model(input logic [6:0] p);
        bit tick;
        bit carry;
        int len;
        m_edges++;
        tick  = (m_edges % TPS == 0);
        carry = tick && m_pm && m_hr == 11 && m_mn == 59 && m_sc == 59;
        if (tick) begin
            m_sc++;
            if (m_sc == 60) begin
                m_sc = 0;
                m_mn++;
                if (m_mn == 60) begin
                    m_mn = 0;
                    if (m_hr == 11)
                        m_pm = !m_pm;  // half day flips at 11 -> 12
                    m_hr = next_hour(m_hr);
                end
            end
        end else begin
            if (p[P_HR])
                m_hr = next_hour(m_hr);
            if (p[P_MIN])
                m_mn = (m_mn + 1) % 60;
            if (p[P_AMPM])
                m_pm = !m_pm;
        end
        if (carry) begin
            advance_day();
            carry_seen = 1'b1;
        end else begin
            if (p[P_MON])
                m_mon = (m_mon == 12) ? 1 : m_mon + 1;
            if (p[P_YEAR])
                m_yr = (m_yr + 1) % 100;
            if (p[P_CENT])
                m_cen = (m_cen + 1) % 100;
            len = month_days(m_mon, m_yr, m_cen);
            if (p[P_DAY])
                m_day = (m_day >= len) ? 1 : m_day + 1;
            if (m_day > len)
                m_day = len;  // day stays inside the month
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus, one call per clock
    task automatic compare_outputs();
        check_equal("time_digits", time_digits, exp_time());
        check_equal("date_digits", date_digits, exp_date());
        check_equal("blink", blink, (m_edges % TPS) < (TPS / 2));
    endtask

    task automatic run_cycle(input logic [6:0] p);
        inc_hr       = p[P_HR];
        inc_min      = p[P_MIN];
        toggle_am_pm = p[P_AMPM];
        inc_month    = p[P_MON];
        inc_day      = p[P_DAY];
        inc_year     = p[P_YEAR];
        inc_cent     = p[P_CENT];
        advance_model(p);
        @(negedge clk_100MHz);
        compare_outputs();
    endtask

    task automatic send_pulse(input int idx);
        if ((m_edges + 1) % TPS == 0)
            run_cycle(7'd0);  // keep clear of the tick cycle
        run_cycle(7'd1 << idx);
    endtask

    task automatic set_date(input int mon, input int day, input int cen, input int yr);
        while (m_cen != cen)
            send_pulse(P_CENT);
        while (m_yr != yr)
            send_pulse(P_YEAR);
        while (m_mon != mon)
            send_pulse(P_MON);
        while (m_day != day)
            send_pulse(P_DAY);
    endtask

    // preset 11:59 pm, then run through the midnight roll
    task automatic run_to_midnight();
        while (m_sc >= 50)
            run_cycle(7'd0);
        while (!m_pm)
            send_pulse(P_AMPM);
        while (m_hr != 11)
            send_pulse(P_HR);
        while (m_mn != 59)
            send_pulse(P_MIN);
        carry_seen = 1'b0;
        while (!carry_seen)
            run_cycle(7'd0);
        check_equal("time_digits", time_digits, {24'h12_00_00, 1'b0});
    endtask

    //////////////////////////////////////////////////
    // vga sync timing and blanking monitor
    int unsigned vga_cyc;
    int unsigned h_fall_at;
    int unsigned v_fall_at;
    int unsigned h_periods;
    bit          h_seen_fall;
    bit          v_seen_fall;
    bit          vsync_checked;
    bit          prev_hsync;
    bit          prev_vsync;
    bit          vga_done;

    always @(negedge clk_100MHz) begin
        if (!rst_n) begin
            vga_cyc       = 0;
            h_periods     = 0;
            h_seen_fall   = 1'b0;
            v_seen_fall   = 1'b0;
            vsync_checked = 1'b0;
            prev_hsync    = 1'b1;
            prev_vsync    = 1'b1;
            vga_done      = 1'b0;
        end else begin
            vga_cyc++;
            if (prev_hsync && !hsync) begin
                if (h_seen_fall) begin
                    check_equal("hsync period", vga_cyc - h_fall_at, H_PERIOD);
                    h_periods++;
                end
                h_seen_fall = 1'b1;
                h_fall_at   = vga_cyc;
            end
            if (!prev_hsync && hsync && h_seen_fall)
                check_equal("hsync low width", vga_cyc - h_fall_at, H_LOW);
            if (prev_vsync && !vsync) begin
                v_seen_fall = 1'b1;
                v_fall_at   = vga_cyc;
            end
            if (!prev_vsync && vsync && v_seen_fall) begin
                check_equal("vsync low width", vga_cyc - v_fall_at, V_LOW);
                vsync_checked = 1'b1;
            end
            if (!hsync || !vsync)
                check_equal("rgb", rgb, 12'h000);  // blank during sync
            prev_hsync = hsync;
            prev_vsync = vsync;
            vga_done   = vsync_checked && (h_periods >= 3);
        end
    end

    //////////////////////////////////////////////////
    // test sequence
    initial begin
        logic [31:0] r;
        logic [6:0]  p;
        rst_n        = 1'b0;
        inc_hr       = 1'b0;
        inc_min      = 1'b0;
        toggle_am_pm = 1'b0;
        inc_month    = 1'b0;
        inc_day      = 1'b0;
        inc_year     = 1'b0;
        inc_cent     = 1'b0;
        reset_model();
        repeat (3) @(negedge clk_100MHz);
        rst_n = 1'b1;

        // reset values, then blink over a few seconds
        check_equal("time_digits", time_digits, {24'h12_00_00, 1'b0});
        check_equal("date_digits", date_digits, 32'h0101_2000);
        compare_outputs();
        repeat (3 * TPS) run_cycle(7'd0);

        // year and century carry at midnight
        set_date(12, 31, 20, 99);
        run_to_midnight();
        check_equal("date_digits", date_digits, 32'h0101_2100);

        // day clamp on month change, then 2100 is not leap
        set_date(1, 31, 21, 0);
        send_pulse(P_MON);
        check_equal("date_digits", date_digits, 32'h0228_2100);
        run_to_midnight();
        check_equal("date_digits", date_digits, 32'h0301_2100);

        set_date(2, 28, 20, 24);
        run_to_midnight();
        check_equal("date_digits", date_digits, 32'h0229_2024);
        run_to_midnight();
        check_equal("date_digits", date_digits, 32'h0301_2024);

        set_date(2, 28, 20, 0);
        run_to_midnight();
        check_equal("date_digits", date_digits, 32'h0229_2000);

        // random single set pulses outside tick cycles
        repeat (4000) begin
            r = next_random();
            p = 7'd0;
            if ((m_edges + 1) % TPS != 0 && r[3:2] == 2'd0)
                p = 7'd1 << (r[15:8] % 7);
            run_cycle(p);
        end

        // keep the model running until a full vsync pulse was seen
        while (!vga_done)
            run_cycle(7'd0);

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
hw/clock_pkg.sv
hw/vga_if.sv
hw/vga_controller.sv
hw/time_counter.sv
hw/calendar.sv
hw/pixel_gen.sv
hw/clock_calendar_top.sv
bench/tb_clock_calendar.sv

// ==== hw/calendar.sv ====
`timescale 1ns/1ps
`default_nettype none

module calendar
    import clock_pkg::*;
(
    input  wire       clk_100MHz,
    input  wire       rst_n,
    input  wire       day_carry,
    input  wire       inc_month,
    input  wire       inc_day,
    input  wire       inc_year,
    input  wire       inc_cent,
    output date_bcd_t date_digits
);

    date_bcd_t  d;
    logic [7:0] mon;
    logic [7:0] day;
    logic [7:0] yr;
    logic [7:0] cen;
    logic [7:0] len_now;
    logic [7:0] mon_n;
    logic [7:0] yr_n;
    logic [7:0] cen_n;
    logic [7:0] len_n;
    logic [7:0] day_n;

    // 10 = 2 mod 4, so an odd tens digit needs ones of 2 or 6
    function automatic logic div4(input logic [7:0] v);
        if (v[4])
            return (v[3:0] == 4'd2) || (v[3:0] == 4'd6);
        return (v[3:0] == 4'd0) || (v[3:0] == 4'd4) || (v[3:0] == 4'd8);
    endfunction

    function automatic logic [7:0] month_len(input logic [7:0] m,
                                             input logic [7:0] y,
                                             input logic [7:0] c);
        logic leap;
        leap = (y == 8'h00) ? div4(c) : div4(y);  // century years use the century
        case (m)
            8'h02:                      return leap ? 8'h29 : 8'h28;
            8'h04, 8'h06, 8'h09, 8'h11: return 8'h30;
            default:                    return 8'h31;
        endcase
    endfunction

    assign mon = {d.mon_10s, d.mon_1s};
    assign day = {d.day_10s, d.day_1s};
    assign yr  = {d.year_10s, d.year_1s};
    assign cen = {d.cent_10s, d.cent_1s};

    assign len_now = month_len(mon, yr, cen);

    //////////////////////////////////////////////////
    // set path, day is held inside the new month
    assign mon_n = inc_month ? bcd_inc(mon, 8'h12, 8'h01) : mon;
    assign yr_n  = inc_year  ? bcd_inc(yr, 8'h99, 8'h00)  : yr;
    assign cen_n = inc_cent  ? bcd_inc(cen, 8'h99, 8'h00) : cen;
    assign len_n = month_len(mon_n, yr_n, cen_n);
    assign day_n = inc_day   ? bcd_inc(day, len_n, 8'h01) : day;

    always_ff @(posedge clk_100MHz) begin
        if (!rst_n) begin
            d <= '{mon_1s: 4'd1, day_1s: 4'd1, cent_10s: 4'd2, default: '0};  // 01/01/2000
        end else if (day_carry) begin
            {d.day_10s, d.day_1s} <= bcd_inc(day, len_now, 8'h01);
            if (day == len_now) begin
                {d.mon_10s, d.mon_1s} <= bcd_inc(mon, 8'h12, 8'h01);
                if (mon == 8'h12) begin
                    {d.year_10s, d.year_1s} <= bcd_inc(yr, 8'h99, 8'h00);
                    if (yr == 8'h99)
                        {d.cent_10s, d.cent_1s} <= bcd_inc(cen, 8'h99, 8'h00);
                end
            end
        end else begin
            {d.mon_10s, d.mon_1s}   <= mon_n;
            {d.year_10s, d.year_1s} <= yr_n;
            {d.cent_10s, d.cent_1s} <= cen_n;
            {d.day_10s, d.day_1s}   <= (day_n > len_n) ? len_n : day_n;  // clamp
        end
    end

    assign date_digits = d;

    a_day_in_month: assert property (@(posedge clk_100MHz) disable iff (!rst_n)
        (day != 8'h00) && (day <= len_now));

endmodule

`default_nettype wire

// ==== hw/clock_calendar_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_calendar_top
    import clock_pkg::*;
#(
    parameter int TICKS_PER_SEC = 100_000_000
) (
    input  wire         clk_100MHz,
    input  wire         rst_n,
    input  wire         inc_hr,         // set pulses, already debounced
    input  wire         inc_min,
    input  wire         toggle_am_pm,
    input  wire         inc_month,
    input  wire         inc_day,
    input  wire         inc_year,
    input  wire         inc_cent,
    output logic        blink,          // 1 Hz led
    output logic        hsync,          // vga connector
    output logic        vsync,
    output logic [11:0] rgb,
    output logic [24:0] time_digits,    // digit readout
    output logic [31:0] date_digits
);

    time_bcd_t time_now;
    date_bcd_t date_now;
    logic      day_carry;

    vga_if vga ();

    vga_controller u_vga_controller (
        .clk_100MHz (clk_100MHz),
        .rst_n      (rst_n),
        .vga        (vga.source),
        .hsync      (hsync),
        .vsync      (vsync)
    );

    time_counter #(
        .TICKS_PER_SEC (TICKS_PER_SEC)
    ) u_time_counter (
        .clk_100MHz   (clk_100MHz),
        .rst_n        (rst_n),
        .inc_hr       (inc_hr),
        .inc_min      (inc_min),
        .toggle_am_pm (toggle_am_pm),
        .time_digits  (time_now),
        .day_carry    (day_carry),
        .blink        (blink)
    );

    calendar u_calendar (
        .clk_100MHz  (clk_100MHz),
        .rst_n       (rst_n),
        .day_carry   (day_carry),
        .inc_month   (inc_month),
        .inc_day     (inc_day),
        .inc_year    (inc_year),
        .inc_cent    (inc_cent),
        .date_digits (date_now)
    );

    pixel_gen u_pixel_gen (
        .clk_100MHz  (clk_100MHz),
        .rst_n       (rst_n),
        .vga         (vga.sink),
        .time_digits (time_now),
        .date_digits (date_now),
        .rgb         (rgb)
    );

    assign time_digits = time_now;
    assign date_digits = date_now;

endmodule

`default_nettype wire

// ==== hw/clock_pkg.sv ====
`default_nettype none

package clock_pkg;

    //////////////////////////////////////////////////
    // bcd digit records
    typedef struct packed {
        logic [3:0] hr_10s;
        logic [3:0] hr_1s;
        logic [3:0] min_10s;
        logic [3:0] min_1s;
        logic [3:0] sec_10s;
        logic [3:0] sec_1s;
        logic       am_pm;      // 1 = pm
    } time_bcd_t;

    typedef struct packed {
        logic [3:0] mon_10s;
        logic [3:0] mon_1s;
        logic [3:0] day_10s;
        logic [3:0] day_1s;
        logic [3:0] cent_10s;
        logic [3:0] cent_1s;
        logic [3:0] year_10s;
        logic [3:0] year_1s;
    } date_bcd_t;

    //////////////////////////////////////////////////
    // 640x480 at 60 Hz, pixels and lines
    localparam logic [9:0] H_ACTIVE = 10'd640;
    localparam logic [9:0] H_FRONT  = 10'd16;
    localparam logic [9:0] H_SYNC   = 10'd96;
    localparam logic [9:0] H_BACK   = 10'd48;
    localparam logic [9:0] V_ACTIVE = 10'd480;
    localparam logic [9:0] V_FRONT  = 10'd10;
    localparam logic [9:0] V_SYNC   = 10'd2;
    localparam logic [9:0] V_BACK   = 10'd33;

    typedef enum logic [1:0] {ACTIVE, FRONT, SYNC, BACK} sync_phase_t;

    // two-digit bcd step, wraps from last back to first
    function automatic logic [7:0] bcd_inc(input logic [7:0] v,
                                           input logic [7:0] last,
                                           input logic [7:0] first);
        if (v == last)
            return first;
        if (v[3:0] == 4'd9)
            return {v[7:4] + 4'd1, 4'd0};  // carry into tens
        return v + 8'd1;
    endfunction

endpackage

`default_nettype wire

// ==== hw/pixel_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_gen
    import clock_pkg::*;
(
    input  wire        clk_100MHz,
    input  wire        rst_n,
    vga_if.sink        vga,
    input  wire        time_bcd_t time_digits,
    input  wire        date_bcd_t date_digits,
    output logic [11:0] rgb
);

    `include "clock_colors.svh"

    localparam logic [9:0] TIME_Y0 = 10'd144;  // top of the time row
    localparam logic [9:0] DATE_Y0 = 10'd288;  // top of the date row
    localparam logic [9:0] CELL_H  = 10'd48;

    logic       in_time_row;
    logic       in_date_row;
    logic [4:0] col;
    logic [4:0] lx;
    logic [9:0] row_y;
    logic [5:0] ly;
    logic [3:0] digit;
    logic       has_digit;
    logic       lit_digit;
    logic       lit_mark;

    // bars in order a b c d e f g
    function automatic logic [6:0] seg_decode(input logic [3:0] v);
        case (v)
            4'd0:    return 7'b1111110;
            4'd1:    return 7'b0110000;
            4'd2:    return 7'b1101101;
            4'd3:    return 7'b1111001;
            4'd4:    return 7'b0110011;
            4'd5:    return 7'b1011011;
            4'd6:    return 7'b1011111;
            4'd7:    return 7'b1110000;
            4'd8:    return 7'b1111111;
            4'd9:    return 7'b1111011;
            default: return 7'b0000000;
        endcase
    endfunction

    // which bars cover this spot of a 32x48 cell
    function automatic logic [6:0] bar_hits(input logic [4:0] px, input logic [5:0] py);
        logic mid_x;
        logic top_y;
        logic bot_y;
        mid_x = (px >= 5'd6) && (px <= 5'd25);
        top_y = (py >= 6'd4) && (py <= 6'd23);
        bot_y = (py >= 6'd24) && (py <= 6'd43);
        return {mid_x && (py >= 6'd2) && (py <= 6'd5),
                (px >= 5'd24) && (px <= 5'd27) && top_y,
                (px >= 5'd24) && (px <= 5'd27) && bot_y,
                mid_x && (py >= 6'd42) && (py <= 6'd45),
                (px >= 5'd4) && (px <= 5'd7) && bot_y,
                (px >= 5'd4) && (px <= 5'd7) && top_y,
                mid_x && (py >= 6'd22) && (py <= 6'd25)};
    endfunction

    assign col         = vga.x[9:5];  // 20 columns of 32 px
    assign lx          = vga.x[4:0];
    assign in_time_row = (vga.y >= TIME_Y0) && (vga.y < TIME_Y0 + CELL_H);
    assign in_date_row = (vga.y >= DATE_Y0) && (vga.y < DATE_Y0 + CELL_H);
    assign row_y       = in_time_row ? vga.y - TIME_Y0 : vga.y - DATE_Y0;
    assign ly          = row_y[5:0];

    //////////////////////////////////////////////////
    // cell layout, HH MM SS pm and MM DD CCYY
    always_comb begin
        digit     = 4'd0;
        has_digit = 1'b1;
        if (in_time_row) begin
            case (col)
                5'd4:    digit = time_digits.hr_10s;
                5'd5:    digit = time_digits.hr_1s;
                5'd7:    digit = time_digits.min_10s;
                5'd8:    digit = time_digits.min_1s;
                5'd10:   digit = time_digits.sec_10s;
                5'd11:   digit = time_digits.sec_1s;
                default: has_digit = 1'b0;
            endcase
        end else if (in_date_row) begin
            case (col)
                5'd4:    digit = date_digits.mon_10s;
                5'd5:    digit = date_digits.mon_1s;
                5'd7:    digit = date_digits.day_10s;
                5'd8:    digit = date_digits.day_1s;
                5'd10:   digit = date_digits.cent_10s;
                5'd11:   digit = date_digits.cent_1s;
                5'd12:   digit = date_digits.year_10s;
                5'd13:   digit = date_digits.year_1s;
                default: has_digit = 1'b0;
            endcase
        end else begin
            has_digit = 1'b0;
        end
    end

    assign lit_digit = has_digit && |(seg_decode(digit) & bar_hits(lx, ly));
    assign lit_mark  = in_time_row && (col == 5'd13) && time_digits.am_pm
                       && (lx >= 5'd4) && (lx <= 5'd27) && (ly >= 6'd16) && (ly <= 6'd31);

    always_ff @(posedge clk_100MHz) begin
        if (!rst_n)
            rgb <= 12'h000;
        else if (vga.p_tick) begin
            if (!vga.video_on)
                rgb <= 12'h000;  // blank outside the window
            else if (lit_digit)
                rgb <= in_time_row ? COLOR_TIME : COLOR_DATE;
            else if (lit_mark)
                rgb <= COLOR_MARK;
            else
                rgb <= COLOR_BG;
        end
    end

endmodule

`default_nettype wire

// ==== hw/time_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module time_counter
    import clock_pkg::*;
#(
    parameter int TICKS_PER_SEC = 100_000_000
) (
    input  wire       clk_100MHz,
    input  wire       rst_n,
    input  wire       inc_hr,
    input  wire       inc_min,
    input  wire       toggle_am_pm,
    output time_bcd_t time_digits,
    output logic      day_carry,
    output logic      blink
);

    localparam int CNT_W = (TICKS_PER_SEC > 1) ? $clog2(TICKS_PER_SEC) : 1;

    logic [CNT_W-1:0] tick_cnt;
    logic             tick;
    time_bcd_t        t;
    logic [7:0]       hr;
    logic [7:0]       mn;
    logic [7:0]       sc;
    logic             at_midnight;

    //////////////////////////////////////////////////
    // one second timebase
    always_ff @(posedge clk_100MHz) begin
        if (!rst_n)
            tick_cnt <= '0;
        else if (tick)
            tick_cnt <= '0;
        else
            tick_cnt <= tick_cnt + 1'b1;
    end

    assign tick  = (tick_cnt == CNT_W'(TICKS_PER_SEC - 1));
    assign blink = (tick_cnt < CNT_W'(TICKS_PER_SEC / 2));  // first half of the second

    assign hr = {t.hr_10s, t.hr_1s};
    assign mn = {t.min_10s, t.min_1s};
    assign sc = {t.sec_10s, t.sec_1s};

    // 11:59:59 pm, next tick starts a new day
    assign at_midnight = t.am_pm && (hr == 8'h11) && (mn == 8'h59) && (sc == 8'h59);
    assign day_carry   = tick && at_midnight;

    //////////////////////////////////////////////////
    // cascaded digits, set pulses only between ticks
    always_ff @(posedge clk_100MHz) begin
        if (!rst_n) begin
            t <= '{hr_10s: 4'd1, hr_1s: 4'd2, default: '0};  // 12:00:00 am
        end else if (tick) begin
            {t.sec_10s, t.sec_1s} <= bcd_inc(sc, 8'h59, 8'h00);
            if (sc == 8'h59) begin
                {t.min_10s, t.min_1s} <= bcd_inc(mn, 8'h59, 8'h00);
                if (mn == 8'h59) begin
                    {t.hr_10s, t.hr_1s} <= bcd_inc(hr, 8'h12, 8'h01);
                    if (hr == 8'h11)
                        t.am_pm <= ~t.am_pm;  // 11 -> 12 flips the half day
                end
            end
        end else begin
            if (inc_hr)
                {t.hr_10s, t.hr_1s} <= bcd_inc(hr, 8'h12, 8'h01);
            if (inc_min)
                {t.min_10s, t.min_1s} <= bcd_inc(mn, 8'h59, 8'h00);
            if (toggle_am_pm)
                t.am_pm <= ~t.am_pm;
        end
    end

    assign time_digits = t;

    a_tens_range: assert property (@(posedge clk_100MHz) disable iff (!rst_n)
        (t.min_10s <= 4'd5) && (t.sec_10s <= 4'd5));

    a_hour_range: assert property (@(posedge clk_100MHz) disable iff (!rst_n)
        (hr >= 8'h01) && (hr <= 8'h12) && (t.hr_1s <= 4'd9));

endmodule

`default_nettype wire

// ==== hw/vga_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_controller
    import clock_pkg::*;
(
    input  wire  clk_100MHz,
    input  wire  rst_n,
    vga_if.source vga,
    output logic hsync,
    output logic vsync
);

    localparam logic [9:0] H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;  // 800
    localparam logic [9:0] V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;  // 525

    logic [1:0]  pix_div;
    logic [9:0]  h_count;
    logic [9:0]  v_count;
    sync_phase_t h_phase;
    sync_phase_t v_phase;

    // same porch layout on both axes
    function automatic sync_phase_t phase_of(input logic [9:0] cnt,
                                             input logic [9:0] active,
                                             input logic [9:0] front,
                                             input logic [9:0] sync);
        if (cnt < active)
            return ACTIVE;
        if (cnt < active + front)
            return FRONT;
        if (cnt < active + front + sync)
            return SYNC;
        return BACK;
    endfunction

    //////////////////////////////////////////////////
    // pixel strobe and raster counters
    always_ff @(posedge clk_100MHz) begin
        if (!rst_n) begin
            pix_div <= 2'd0;
            h_count <= 10'd0;
            v_count <= 10'd0;
        end else begin
            pix_div <= pix_div + 2'd1;
            if (vga.p_tick) begin
                if (h_count == H_TOTAL - 10'd1) begin
                    h_count <= 10'd0;
                    v_count <= (v_count == V_TOTAL - 10'd1) ? 10'd0 : v_count + 10'd1;
                end else begin
                    h_count <= h_count + 10'd1;
                end
            end
        end
    end

    assign vga.p_tick   = (pix_div == 2'd3);  // one cycle in four
    assign vga.x        = h_count;
    assign vga.y        = v_count;
    assign h_phase      = phase_of(h_count, H_ACTIVE, H_FRONT, H_SYNC);
    assign v_phase      = phase_of(v_count, V_ACTIVE, V_FRONT, V_SYNC);
    assign vga.video_on = (h_phase == ACTIVE) && (v_phase == ACTIVE);

    // sync levels trail the counters by one clock
    always_ff @(posedge clk_100MHz) begin
        if (!rst_n) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            hsync <= (h_phase != SYNC);  // active low
            vsync <= (v_phase != SYNC);
        end
    end

    a_no_sync_in_window: assert property (@(posedge clk_100MHz) disable iff (!rst_n)
        !(!hsync && vga.video_on));

endmodule

`default_nettype wire

// ==== hw/vga_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// raster position from the timing generator to the pixel path
interface vga_if;
    logic [9:0] x;          // pixel column, 0..799
    logic [9:0] y;          // line, 0..524
    logic       video_on;   // inside the 640x480 window
    logic       p_tick;     // 25 MHz pixel strobe

    modport source (
        output x, y, video_on, p_tick
    );

    modport sink (
        input x, y, video_on, p_tick
    );
endinterface

`default_nettype wire

// ==== include/clock_colors.svh ====
`ifndef CLOCK_COLORS_SVH
`define CLOCK_COLORS_SVH

// 12-bit rgb, 4 bits per channel, r in the top nibble
localparam logic [11:0] COLOR_BG   = 12'h113;  // dark blue backdrop
localparam logic [11:0] COLOR_TIME = 12'h0f4;  // green time digits
localparam logic [11:0] COLOR_DATE = 12'hfa0;  // amber date digits
localparam logic [11:0] COLOR_MARK = 12'hf22;  // red pm block

`endif
